// File: zbuf_consts.svh
`ifndef ZBUF_CONSTS_SVH
`define ZBUF_CONSTS_SVH

// ========================================
// Depth stage sizes
// ========================================

`define ZB_ADDR_BITS 26
`define ZB_FIFO_LOG2 4 // 16 entries
`define ZB_DEPTH_OFFSET 4 // Depth word follows the color word

// Address, color, old depth, new depth, done
`define ZB_FRAG_BITS (`ZB_ADDR_BITS + 24 + 32 + 32 + 1)

`endif

// File: zbuf_pkg.sv
package zbuf_pkg;

    // Color as stored in frame memory
    typedef struct packed {
        logic [7:0] pad;
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } pixel_color_t;

    // One memory word, either a color or a depth
    typedef union packed {
        pixel_color_t color;
        logic [31:0] depth;
    } mem_word_t;

endpackage

// File: frag_if.sv
`timescale 1ns/1ns
`include "zbuf_consts.svh"

interface frag_if;
    logic push; // One entry per high cycle
    logic [`ZB_ADDR_BITS-1:0] addr;
    logic [23:0] color;
    logic [31:0] old_depth;
    logic [31:0] new_depth;
    logic done;

    modport source (
        output push, addr, color, old_depth, new_depth, done
    );

    modport sink (
        input push, addr, color, old_depth, new_depth, done
    );
endinterface

// File: fifo.sv
`timescale 1ns/1ns
`include "zbuf_consts.svh"

module fifo #(
    parameter int dbits = `ZB_FRAG_BITS,
    parameter int log2_size = `ZB_FIFO_LOG2
) (
    input logic clock,
    input logic reset,
    frag_if.sink in_port,
    input logic pop,
    output logic [dbits-1:0] dout,
    output logic empty,
    output logic half_full,
    output logic almost_full
);

    localparam logic [log2_size:0] half_level = 1'b1 << (log2_size - 1);
    localparam logic [log2_size:0] last_free = {1'b0, {log2_size{1'b1}}};

    logic [dbits-1:0] mem [2**log2_size];
    logic [dbits-1:0] din;
    logic [log2_size-1:0] wr_ptr;
    logic [log2_size-1:0] rd_ptr;
    logic [log2_size:0] count;
    logic wr_en;
    logic rd_en;

    assign din = {in_port.done, in_port.new_depth, in_port.old_depth,
                  in_port.color, in_port.addr};

    assign wr_en = in_port.push && !count[log2_size]; // Drop nothing unless full
    assign rd_en = pop && !empty;

    assign empty = (count == '0);
    assign half_full = (count >= half_level);
    assign almost_full = (count >= last_free);
    assign dout = mem[rd_ptr]; // Head entry

    always_ff @(posedge clock) begin
        if (wr_en) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (wr_en) wr_ptr <= wr_ptr + 1'b1;
            if (rd_en) rd_ptr <= rd_ptr + 1'b1;
            case ({wr_en, rd_en})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: depth_fetch.sv
`timescale 1ns/1ns
`include "zbuf_consts.svh"

module depth_fetch (
    input logic clock,
    input logic reset,
    input logic frag_valid,
    input logic [`ZB_ADDR_BITS-1:0] frag_addr,
    input logic [23:0] frag_color,
    input logic [31:0] frag_depth,
    input logic frag_done,
    input logic [31:0] rd_readdata,
    input logic rd_readdatavalid,
    input logic rd_waitrequest,
    input logic fifo_almost_full,
    input logic fifo_half_full,
    output logic [`ZB_ADDR_BITS-1:0] rd_address,
    output logic rd_read,
    output logic stall,
    frag_if.source out_port
);

    typedef enum logic [1:0] {s_idle, s_read, s_wait} state_t;
    state_t state;

    logic [`ZB_ADDR_BITS-1:0] addr_q;
    logic [23:0] color_q;
    logic [31:0] new_depth_q;
    logic [31:0] old_depth_q;
    logic done_q;
    logic data_held; // Old depth waiting for FIFO room
    logic push_q;

    assign stall = (state != s_idle) || fifo_half_full;
    assign rd_address = addr_q + `ZB_ADDR_BITS'(`ZB_DEPTH_OFFSET);

    assign out_port.push = push_q;
    assign out_port.addr = addr_q;
    assign out_port.color = color_q;
    assign out_port.old_depth = old_depth_q;
    assign out_port.new_depth = new_depth_q;
    assign out_port.done = done_q;

    // Fragment payload
    always_ff @(posedge clock) begin
        if (state == s_idle && frag_valid && !stall) begin
            addr_q <= frag_addr;
            color_q <= frag_color;
            new_depth_q <= frag_depth;
            done_q <= frag_done;
        end
        if (state == s_wait && rd_readdatavalid) begin
            old_depth_q <= rd_readdata;
        end
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state <= s_idle;
            rd_read <= 1'b0;
            push_q <= 1'b0;
            data_held <= 1'b0;
        end else begin
            push_q <= 1'b0;
            case (state)
                s_idle: begin
                    if (frag_valid && !stall) begin
                        rd_read <= 1'b1; // Read goes out next cycle
                        state <= s_read;
                    end
                end
                s_read: begin
                    if (!rd_waitrequest) begin
                        rd_read <= 1'b0;
                        state <= s_wait;
                    end
                end
                s_wait: begin
                    if (rd_readdatavalid && !fifo_almost_full) begin
                        push_q <= 1'b1;
                        state <= s_idle;
                    end else if (rd_readdatavalid) begin
                        data_held <= 1'b1;
                    end else if (data_held && !fifo_almost_full) begin
                        data_held <= 1'b0;
                        push_q <= 1'b1;
                        state <= s_idle;
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

endmodule

// File: ztest.sv
`timescale 1ns/1ns
`include "zbuf_consts.svh"

module ztest (
    input logic clock,
    input logic reset,
    input logic [`ZB_FRAG_BITS-1:0] head,
    input logic empty,
    input logic wr_waitrequest,
    output logic pop,
    output logic [`ZB_ADDR_BITS-1:0] wr_address,
    output logic wr_write,
    output zbuf_pkg::mem_word_t wr_writedata,
    output logic [3:0] wr_byteenable,
    output logic done
);

    import zbuf_pkg::*;

    localparam int aw = `ZB_ADDR_BITS;

    typedef enum logic [1:0] {s_idle, s_write_color, s_write_depth, s_pop} state_t;
    state_t state;

    // ========================================
    // Head entry fields
    // ========================================

    logic [aw-1:0] head_addr;
    logic [23:0] head_color;
    logic [31:0] head_old_depth;
    logic [31:0] head_new_depth;
    logic head_done;
    logic nearer;

    assign head_addr = head[aw-1:0];
    assign head_color = head[aw+23:aw];
    assign head_old_depth = head[aw+55:aw+24];
    assign head_new_depth = head[aw+87:aw+56];
    assign head_done = head[aw+88];

    assign nearer = head_new_depth < head_old_depth; // Equal depth fails

    assign wr_byteenable = 4'hf;

    logic [31:0] new_depth_q;
    logic done_q;

    // ========================================
    // Write sequencer
    // ========================================

    always_ff @(posedge clock) begin
        if (state == s_idle && !empty) begin
            new_depth_q <= head_new_depth;
            done_q <= head_done;
            wr_address <= head_addr;
            wr_writedata.color <= pixel_color_t'({8'h00, head_color});
        end else if (state == s_write_color && !wr_waitrequest) begin
            wr_address <= wr_address + aw'(`ZB_DEPTH_OFFSET);
            wr_writedata.depth <= new_depth_q;
        end
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state <= s_idle;
            pop <= 1'b0;
            wr_write <= 1'b0;
            done <= 1'b0;
        end else begin
            pop <= 1'b0;
            done <= 1'b0;
            case (state)
                s_idle: begin
                    if (!empty) begin
                        pop <= 1'b1;
                        if (nearer) begin
                            wr_write <= 1'b1;
                            state <= s_write_color;
                        end else begin
                            state <= s_pop;
                        end
                    end
                end
                s_write_color: begin
                    if (!wr_waitrequest) begin
                        state <= s_write_depth; // wr_write stays high
                    end
                end
                s_write_depth: begin
                    if (!wr_waitrequest) begin
                        wr_write <= 1'b0;
                        done <= done_q;
                        state <= s_idle;
                    end
                end
                s_pop: begin
                    done <= done_q; // Failed fragment writes nothing
                    state <= s_idle;
                end
                default: state <= s_idle;
            endcase
        end
    end

endmodule

// File: bus_arbiter.sv
`timescale 1ns/1ns
`include "zbuf_consts.svh"

module bus_arbiter (
    input logic clock,
    input logic reset,
    input logic [`ZB_ADDR_BITS-1:0] rd_address,
    input logic rd_read,
    input logic [`ZB_ADDR_BITS-1:0] wr_address,
    input logic wr_write,
    input logic [31:0] wr_writedata,
    input logic [3:0] wr_byteenable,
    input logic [31:0] mem_readdata,
    input logic mem_readdatavalid,
    input logic mem_waitrequest,
    output logic [`ZB_ADDR_BITS-1:0] mem_address,
    output logic mem_read,
    output logic mem_write,
    output logic [3:0] mem_byteenable,
    output logic [31:0] mem_writedata,
    output logic rd_waitrequest,
    output logic [31:0] rd_readdata,
    output logic rd_readdatavalid,
    output logic wr_waitrequest
);

    typedef enum logic [1:0] {own_none, own_rd, own_wr} owner_t;
    owner_t owner;
    owner_t grant;

    // Held owner first, then write over read
    always_comb begin
        if (owner != own_none) grant = owner;
        else if (wr_write) grant = own_wr;
        else if (rd_read) grant = own_rd;
        else grant = own_none;
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            owner <= own_none;
        end else if (grant != own_none && mem_waitrequest) begin
            owner <= grant;
        end else begin
            owner <= own_none; // Request completed or none pending
        end
    end

    assign mem_read = (grant == own_rd);
    assign mem_write = (grant == own_wr);
    assign mem_address = (grant == own_wr) ? wr_address : rd_address;
    assign mem_byteenable = (grant == own_wr) ? wr_byteenable : 4'hf;
    assign mem_writedata = wr_writedata;

    assign rd_waitrequest = (grant != own_rd) || mem_waitrequest;
    assign wr_waitrequest = (grant != own_wr) || mem_waitrequest;

    // Only reads return data
    assign rd_readdata = mem_readdata;
    assign rd_readdatavalid = mem_readdatavalid;

endmodule

// File: zbuf_top.sv
`timescale 1ns/1ns
`include "zbuf_consts.svh"

module zbuf_top (
    input logic clock,
    input logic reset,
    input logic frag_valid,
    input logic [`ZB_ADDR_BITS-1:0] frag_addr,
    input logic [23:0] frag_color,
    input logic [31:0] frag_depth,
    input logic frag_done,
    output logic stall,
    output logic done,
    output logic [`ZB_ADDR_BITS-1:0] mem_address,
    output logic mem_read,
    output logic mem_write,
    output logic [3:0] mem_byteenable,
    output logic [31:0] mem_writedata,
    input logic [31:0] mem_readdata,
    input logic mem_readdatavalid,
    input logic mem_waitrequest
);

    logic [`ZB_ADDR_BITS-1:0] rd_address;
    logic rd_read;
    logic [31:0] rd_readdata;
    logic rd_readdatavalid;
    logic rd_waitrequest;
    logic [`ZB_ADDR_BITS-1:0] wr_address;
    logic wr_write;
    logic [31:0] wr_writedata;
    logic [3:0] wr_byteenable;
    logic wr_waitrequest;
    logic [`ZB_FRAG_BITS-1:0] head;
    logic fifo_empty;
    logic fifo_half_full;
    logic fifo_almost_full;
    logic pop;

    frag_if frag_bus ();

    depth_fetch u_fetch (
        .clock(clock),
        .reset(reset),
        .frag_valid(frag_valid),
        .frag_addr(frag_addr),
        .frag_color(frag_color),
        .frag_depth(frag_depth),
        .frag_done(frag_done),
        .rd_readdata(rd_readdata),
        .rd_readdatavalid(rd_readdatavalid),
        .rd_waitrequest(rd_waitrequest),
        .fifo_almost_full(fifo_almost_full),
        .fifo_half_full(fifo_half_full),
        .rd_address(rd_address),
        .rd_read(rd_read),
        .stall(stall),
        .out_port(frag_bus.source)
    );

    fifo #(
        .dbits(`ZB_FRAG_BITS),
        .log2_size(`ZB_FIFO_LOG2)
    ) u_fifo (
        .clock(clock),
        .reset(reset),
        .in_port(frag_bus.sink),
        .pop(pop),
        .dout(head),
        .empty(fifo_empty),
        .half_full(fifo_half_full),
        .almost_full(fifo_almost_full)
    );

    ztest u_ztest (
        .clock(clock),
        .reset(reset),
        .head(head),
        .empty(fifo_empty),
        .wr_waitrequest(wr_waitrequest),
        .pop(pop),
        .wr_address(wr_address),
        .wr_write(wr_write),
        .wr_writedata(wr_writedata),
        .wr_byteenable(wr_byteenable),
        .done(done)
    );

    bus_arbiter u_arbiter (
        .clock(clock),
        .reset(reset),
        .rd_address(rd_address),
        .rd_read(rd_read),
        .wr_address(wr_address),
        .wr_write(wr_write),
        .wr_writedata(wr_writedata),
        .wr_byteenable(wr_byteenable),
        .mem_readdata(mem_readdata),
        .mem_readdatavalid(mem_readdatavalid),
        .mem_waitrequest(mem_waitrequest),
        .mem_address(mem_address),
        .mem_read(mem_read),
        .mem_write(mem_write),
        .mem_byteenable(mem_byteenable),
        .mem_writedata(mem_writedata),
        .rd_waitrequest(rd_waitrequest),
        .rd_readdata(rd_readdata),
        .rd_readdatavalid(rd_readdatavalid),
        .wr_waitrequest(wr_waitrequest)
    );

endmodule

// File: zbuf_properties.sv
`timescale 1ns/1ns
`include "zbuf_consts.svh"

module zbuf_properties (
    input logic clock,
    input logic reset,
    input logic frag_valid,
    input logic stall,
    input logic done,
    input logic [`ZB_ADDR_BITS-1:0] mem_address,
    input logic mem_read,
    input logic mem_write,
    input logic [31:0] mem_writedata,
    input logic mem_waitrequest
);

    // ========================================
    // Memory port
    // ========================================

    one_request: assert property (@(posedge clock) disable iff (!reset)
        !(mem_read && mem_write))
        else $error("mem_read and mem_write are high together");

    hold_read: assert property (@(posedge clock) disable iff (!reset)
        (mem_read && mem_waitrequest) |=> (mem_read && $stable(mem_address)))
        else $error("read request changed while waitrequest was high");

    hold_write: assert property (@(posedge clock) disable iff (!reset)
        (mem_write && mem_waitrequest) |=>
            (mem_write && $stable(mem_address) && $stable(mem_writedata)))
        else $error("write request changed while waitrequest was high");

    // ========================================
    // Fragment side
    // ========================================

    stall_rule: assert property (@(posedge clock) disable iff (!reset)
        frag_valid |-> !stall)
        else $error("frag_valid asserted while stall is high");

    single_done: assert property (@(posedge clock) disable iff (!reset)
        done |=> !done)
        else $error("done stayed high for two cycles");

endmodule

bind zbuf_top zbuf_properties u_props (
    .clock(clock),
    .reset(reset),
    .frag_valid(frag_valid),
    .stall(stall),
    .done(done),
    .mem_address(mem_address),
    .mem_read(mem_read),
    .mem_write(mem_write),
    .mem_writedata(mem_writedata),
    .mem_waitrequest(mem_waitrequest)
);

// File: zbuf_tb.sv
`timescale 1ns/1ns
`include "zbuf_consts.svh"

module zbuf_tb;

    import zbuf_pkg::*;

    localparam int mem_words = 4096;
    localparam int total_frags = 38;
    localparam int watchdog_cycles = total_frags * 40 + 400;

    logic clock;
    logic reset;
    logic frag_valid;
    logic [`ZB_ADDR_BITS-1:0] frag_addr;
    logic [23:0] frag_color;
    logic [31:0] frag_depth;
    logic frag_done;
    logic stall;
    logic done;
    logic [`ZB_ADDR_BITS-1:0] mem_address;
    logic mem_read;
    logic mem_write;
    logic [3:0] mem_byteenable;
    logic [31:0] mem_writedata;
    logic [31:0] mem_readdata = '0;
    logic mem_readdatavalid = 1'b0;
    logic mem_waitrequest = 1'b0;

    logic [31:0] mem [mem_words];
    logic [31:0] ref_mem [mem_words]; // Memory as the depth rule predicts
    logic wait_enable;
    int read_countdown = 0;
    logic [31:0] read_word = '0;
    int write_count = 0;
    int done_count = 0;
    int writes_at_done = 0; // Writes seen when the last done rose
    logic [3:0] last_byteenable = '0;
    int bad_byteenables = 0;
    int expected_writes;
    int errors;
    int failures;
    string test_name;

    zbuf_top UUT (
        .clock(clock),
        .reset(reset),
        .frag_valid(frag_valid),
        .frag_addr(frag_addr),
        .frag_color(frag_color),
        .frag_depth(frag_depth),
        .frag_done(frag_done),
        .stall(stall),
        .done(done),
        .mem_address(mem_address),
        .mem_read(mem_read),
        .mem_write(mem_write),
        .mem_byteenable(mem_byteenable),
        .mem_writedata(mem_writedata),
        .mem_readdata(mem_readdata),
        .mem_readdatavalid(mem_readdatavalid),
        .mem_waitrequest(mem_waitrequest)
    );

    always #10 clock = ~clock;

    // ========================================
    // Memory model
    // ========================================

    function automatic int word_index(input logic [`ZB_ADDR_BITS-1:0] addr);
        return int'(addr[13:2]);
    endfunction

    always @(negedge clock) begin
        mem_readdatavalid = 1'b0;
        if (read_countdown > 0) begin
            read_countdown = read_countdown - 1;
            if (read_countdown == 0) begin
                mem_readdatavalid = 1'b1;
                mem_readdata = read_word;
            end
        end
        mem_waitrequest = wait_enable && ($urandom_range(2, 0) == 0); // Decided for this cycle
        if (mem_read && !mem_waitrequest) begin
            read_word = mem[word_index(mem_address)];
            read_countdown = $urandom_range(4, 1);
        end
        if (mem_write && !mem_waitrequest) begin
            mem[word_index(mem_address)] = mem_writedata;
            last_byteenable = mem_byteenable;
            if (mem_byteenable != 4'hf) bad_byteenables = bad_byteenables + 1;
            write_count = write_count + 1;
        end
        if (done) begin
            done_count = done_count + 1;
            writes_at_done = write_count;
        end
    end

    // ========================================
    // Helpers
    // ========================================

    task automatic value_error(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        errors = errors + 1;
        $display("** Error in %s: %s, expected 0x%h, actual 0x%h",
                 test_name, what, expected, actual);
    endtask

    task automatic fail_note(input string what);
        failures = failures + 1;
        $display("Failure in %s: %s", test_name, what);
    endtask

    task automatic set_word(input logic [`ZB_ADDR_BITS-1:0] addr, input logic [31:0] value);
        mem[word_index(addr)] = value;
        ref_mem[word_index(addr)] = value;
    endtask

    // Updates the reference, then offers the fragment once stall is low
    task automatic send_frag(input logic [`ZB_ADDR_BITS-1:0] addr, input logic [23:0] color,
                             input logic [31:0] depth, input logic last);
        int color_index;
        int depth_index;
        color_index = word_index(addr);
        depth_index = word_index(addr + `ZB_ADDR_BITS'(`ZB_DEPTH_OFFSET));
        if (depth < ref_mem[depth_index]) begin
            ref_mem[color_index] = {8'h00, color};
            ref_mem[depth_index] = depth;
            expected_writes = expected_writes + 2;
        end
        @(negedge clock);
        while (stall) @(negedge clock);
        frag_valid = 1'b1;
        frag_addr = addr;
        frag_color = color;
        frag_depth = depth;
        frag_done = last;
        @(negedge clock);
        frag_valid = 1'b0;
        frag_done = 1'b0;
    endtask

    task automatic wait_done(input int start, input int limit);
        int cycles;
        cycles = 0;
        while (done_count == start && cycles < limit) begin
            @(negedge clock);
            cycles = cycles + 1;
        end
        if (done_count == start) fail_note("timed out waiting for the done pulse");
    endtask

    task automatic compare_memory();
        int shown;
        shown = 0;
        for (int i = 0; i < mem_words; i++) begin
            if (mem[i] !== ref_mem[i]) begin
                if (shown < 5) value_error($sformatf("memory word %0d", i), ref_mem[i], mem[i]);
                else errors = errors + 1;
                shown = shown + 1;
            end
        end
    endtask

    // ========================================
    // Tests
    // ========================================

    task automatic test_reset();
        test_name = "test_reset";
        @(negedge clock);
        if (mem_read !== 1'b0) value_error("mem_read", 32'd0, 32'(mem_read));
        if (mem_write !== 1'b0) value_error("mem_write", 32'd0, 32'(mem_write));
        if (done !== 1'b0) value_error("done", 32'd0, 32'(done));
        if (stall !== 1'b0) value_error("stall", 32'd0, 32'(stall));
    endtask

    task automatic test_pass();
        mem_word_t word;
        int start;
        test_name = "test_pass";
        set_word(26'h100, 32'h00ff_ffff);
        set_word(26'h104, 32'h0000_8000);
        start = done_count;
        send_frag(26'h100, 24'h12_34_56, 32'h0000_1000, 1'b1);
        wait_done(start, 100);
        repeat (10) @(negedge clock);
        word = mem[word_index(26'h100)];
        if (word.color.pad !== 8'h00) value_error("pad", 32'h00, 32'(word.color.pad));
        if (word.color.red !== 8'h12) value_error("red", 32'h12, 32'(word.color.red));
        if (word.color.green !== 8'h34) value_error("green", 32'h34, 32'(word.color.green));
        if (word.color.blue !== 8'h56) value_error("blue", 32'h56, 32'(word.color.blue));
        word = mem[word_index(26'h104)];
        if (word.depth !== 32'h0000_1000) value_error("depth", 32'h0000_1000, word.depth);
        if (last_byteenable !== 4'hf) value_error("byteenable", 32'hf, 32'(last_byteenable));
        if (write_count != expected_writes)
            value_error("write count", 32'(expected_writes), 32'(write_count));
    endtask

    task automatic test_fail();
        int start;
        int start_writes;
        test_name = "test_fail";
        set_word(26'h200, 32'h0011_2233);
        set_word(26'h204, 32'h0000_4000);
        set_word(26'h210, 32'h0044_5566);
        set_word(26'h214, 32'h0000_4000);
        start = done_count;
        start_writes = write_count;
        send_frag(26'h200, 24'haa_bb_cc, 32'h0000_4000, 1'b0); // Equal
        send_frag(26'h210, 24'hdd_ee_ff, 32'h0000_4001, 1'b1); // Farther
        wait_done(start, 200);
        repeat (10) @(negedge clock);
        if (write_count != start_writes)
            value_error("write count", 32'(start_writes), 32'(write_count));
        compare_memory();
    endtask

    task automatic test_done();
        logic [`ZB_ADDR_BITS-1:0] pixel;
        logic [31:0] depth;
        int start;
        test_name = "test_done";
        start = done_count;
        for (int i = 0; i < 5; i++) begin
            pixel = 26'h300 + 26'(8 * i);
            set_word(pixel + 26'd4, 32'h8000_0000);
            depth = (i % 2 == 0) ? 32'h0000_1000 + 32'(i) : 32'h9000_0000;
            send_frag(pixel, 24'h40_00_00 + 24'(i), depth, i == 4);
        end
        wait_done(start, 300);
        repeat (10) @(negedge clock);
        if (done_count != start + 1) value_error("done pulses", 32'(start + 1), 32'(done_count));
        if (writes_at_done != expected_writes)
            value_error("writes before done", 32'(expected_writes), 32'(writes_at_done));
        if (write_count != expected_writes)
            value_error("write count", 32'(expected_writes), 32'(write_count));
        compare_memory();
    endtask

    task automatic test_backpressure();
        logic [`ZB_ADDR_BITS-1:0] pixel;
        logic [31:0] depth;
        int start;
        test_name = "test_backpressure";
        wait_enable = 1'b1;
        start = done_count;
        for (int i = 0; i < 30; i++) begin
            pixel = 26'h1000 + 26'(8 * i);
            set_word(pixel + 26'd4, 32'h8000_0000);
            depth = (i % 7 == 3) ? 32'h8000_0000 : $urandom; // Some equal depths
            send_frag(pixel, 24'($urandom), depth, i == 29);
        end
        wait_done(start, 30 * 40);
        repeat (10) @(negedge clock);
        wait_enable = 1'b0;
        if (done_count != start + 1) value_error("done pulses", 32'(start + 1), 32'(done_count));
        if (write_count != expected_writes)
            value_error("write count", 32'(expected_writes), 32'(write_count));
        compare_memory();
    endtask

    // ========================================
    // Main sequence and watchdog
    // ========================================

    initial begin
        void'($urandom(87218));
        clock = 1'b0;
        reset = 1'b0;
        frag_valid = 1'b0;
        frag_addr = '0;
        frag_color = '0;
        frag_depth = '0;
        frag_done = 1'b0;
        wait_enable = 1'b0;
        expected_writes = 0;
        errors = 0;
        failures = 0;
        test_name = "setup";
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = 32'h3c00_0000 ^ (32'(i) * 32'h0001_0101);
            ref_mem[i] = mem[i];
        end
        repeat (5) @(negedge clock);
        reset = 1'b1;

        test_reset();
        test_pass();
        test_fail();
        test_done();
        test_backpressure();

        test_name = "summary";
        if (bad_byteenables != 0) fail_note("a memory write had a partial byte enable");
        $display("Errors: %0d wrong values, %0d other failures", errors, failures);
        if (errors == 0 && failures == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clock);
        $display("Watchdog expired after %0d cycles, the run did not finish", watchdog_cycles);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// File: flist.f
+incdir+.
zbuf_pkg.sv
frag_if.sv
fifo.sv
depth_fetch.sv
ztest.sv
bus_arbiter.sv
zbuf_top.sv
zbuf_properties.sv
zbuf_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the depth-test stage simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module zbuf_tb -f flist.f -o zbuf_sim
./obj_dir/zbuf_sim > sim.log 2>&1
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
echo "Simulation finished without failures"
